// File: rtl/udp_csum_pkg.sv
// shared field widths, protocol constants and buffer depths
// plus the checksum engine state type
package udp_csum_pkg;

    // header field types
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // byte count used by both udp length and ip total length
    typedef logic [15:0] udp_len_t;

    // finished checksum and the unfolded running sum
    typedef logic [15:0] csum_t;
    typedef logic [31:0] csum_acc_t;

    typedef logic [7:0] payload_byte_t;

    // protocol constants
    localparam logic [7:0] UDP_PROTOCOL  = 8'd17;
    localparam udp_len_t   UDP_HDR_BYTES = 16'd8;

    // ip header without options
    localparam udp_len_t   IP_HDR_BYTES  = 16'd20;

    // buffer sizes are powers of two
    localparam int PAYLOAD_FIFO_DEPTH  = 2048;
    localparam int HEADER_QUEUE_DEPTH  = 8;
    localparam int HEADER_QUEUE_ADDR_W = $clog2(HEADER_QUEUE_DEPTH);

    // checksum engine sequence
    // three header sums and then payload bytes until tlast
    typedef enum logic [2:0] {
        state_idle,
        state_sum_addr_src,
        state_sum_addr_dst,
        state_sum_ports,
        state_sum_payload,
        state_finish
    } engine_state_t;

endpackage

// File: rtl/udp_csum_engine.sv
// header capture, sum state machine and one's-complement accumulator
// producing udp length and checksum per frame
`timescale 1ns/1ps

module udp_csum_engine (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        s_hdr_valid,
    output logic                        s_hdr_ready,
    input  udp_csum_pkg::ip_addr_t      s_ip_source_ip,
    input  udp_csum_pkg::ip_addr_t      s_ip_dest_ip,
    input  udp_csum_pkg::udp_port_t     s_udp_source_port,
    input  udp_csum_pkg::udp_port_t     s_udp_dest_port,
    input  udp_csum_pkg::payload_byte_t s_payload_tdata,
    input  logic                        s_payload_tvalid,
    input  logic                        s_payload_tready,
    input  logic                        s_payload_tlast,
    input  logic                        queue_ready,
    output logic                        payload_accept,
    output logic                        busy,
    output logic                        result_valid,
    output udp_csum_pkg::ip_addr_t      result_source_ip,
    output udp_csum_pkg::ip_addr_t      result_dest_ip,
    output udp_csum_pkg::udp_port_t     result_source_port,
    output udp_csum_pkg::udp_port_t     result_dest_port,
    output udp_csum_pkg::udp_len_t      result_length,
    output udp_csum_pkg::csum_t         result_checksum
);
    import udp_csum_pkg::*;

    engine_state_t state_reg, state_next;
    csum_acc_t     acc_reg, acc_next;
    udp_len_t      length_next;
    logic [16:0]   fold;
    logic          store_hdr;
    logic          hdr_ready_next;
    logic          byte_in;

    assign payload_accept = (state_reg == state_sum_payload);
    assign byte_in = s_payload_tvalid && s_payload_tready;

    // first fold adds the high half into the low half
    assign fold = {1'b0, acc_reg[15:0]} + {1'b0, acc_reg[31:16]};

    always_comb begin
        state_next = state_reg;
        acc_next = acc_reg;
        length_next = result_length;
        hdr_ready_next = 1'b0;
        store_hdr = 1'b0;

        case (state_reg)
            state_idle: begin
                hdr_ready_next = queue_ready;
                if (s_hdr_valid && s_hdr_ready) begin
                    store_hdr = 1'b1;
                    hdr_ready_next = 1'b0;
                    // protocol word plus the udp header length counted twice
                    acc_next = csum_acc_t'(UDP_PROTOCOL) + csum_acc_t'(UDP_HDR_BYTES)
                        + csum_acc_t'(UDP_HDR_BYTES);
                    length_next = UDP_HDR_BYTES;
                    state_next = state_sum_addr_src;
                end
            end
            state_sum_addr_src: begin
                acc_next = acc_reg + result_source_ip[31:16] + result_source_ip[15:0];
                state_next = state_sum_addr_dst;
            end
            state_sum_addr_dst: begin
                acc_next = acc_reg + result_dest_ip[31:16] + result_dest_ip[15:0];
                state_next = state_sum_ports;
            end
            state_sum_ports: begin
                acc_next = acc_reg + result_source_port + result_dest_port;
                state_next = state_sum_payload;
            end
            state_sum_payload: begin
                if (byte_in) begin
                    // even count means high byte of a word
                    // each byte adds 2 since the length is summed twice
                    if (result_length[0]) begin
                        acc_next = acc_reg + csum_acc_t'(s_payload_tdata) + 32'd2;
                    end else begin
                        acc_next = acc_reg + csum_acc_t'({s_payload_tdata, 8'h00}) + 32'd2;
                    end
                    length_next = result_length + 16'd1;
                    if (s_payload_tlast) begin
                        state_next = state_finish;
                    end
                end
            end
            state_finish: begin
                state_next = state_idle;
            end
            default: begin
                state_next = state_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= state_idle;
            s_hdr_ready <= 1'b0;
            result_valid <= 1'b0;
            busy <= 1'b0;
        end else begin
            state_reg <= state_next;
            s_hdr_ready <= hdr_ready_next;
            result_valid <= (state_reg == state_finish);
            busy <= (state_next != state_idle);
        end
    end

    always_ff @(posedge clk) begin
        acc_reg <= acc_next;
        result_length <= length_next;
        if (store_hdr) begin
            result_source_ip <= s_ip_source_ip;
            result_dest_ip <= s_ip_dest_ip;
            result_source_port <= s_udp_source_port;
            result_dest_port <= s_udp_dest_port;
        end
        // second fold takes the carry before the inversion
        if (state_reg == state_finish) begin
            result_checksum <= ~(fold[15:0] + fold[16]);
        end
    end

    // the fifo only takes bytes while this frame is being summed
    assert property (@(posedge clk) disable iff (rst)
        (s_payload_tvalid && s_payload_tready) |-> (state_reg == state_sum_payload));

endmodule

// File: rtl/payload_fifo.sv
// byte fifo with last flag
// holds payload while the checksum is computed
`timescale 1ns/1ps

module payload_fifo #(
    parameter int DEPTH = udp_csum_pkg::PAYLOAD_FIFO_DEPTH
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        payload_accept,
    input  udp_csum_pkg::payload_byte_t s_payload_tdata,
    input  logic                        s_payload_tvalid,
    output logic                        s_payload_tready,
    input  logic                        s_payload_tlast,
    output udp_csum_pkg::payload_byte_t m_payload_tdata,
    output logic                        m_payload_tvalid,
    input  logic                        m_payload_tready,
    output logic                        m_payload_tlast
);
    import udp_csum_pkg::*;

    // DEPTH must be a power of two
    localparam int ADDR_W = $clog2(DEPTH);

    payload_byte_t   data_mem [DEPTH];
    logic            last_mem [DEPTH];
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic            full;
    logic            empty;
    logic            wr_en;
    logic            rd_en;

    // extra pointer bit tells full from empty
    assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W])
        && (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    // input only opens while the engine sums payload
    assign s_payload_tready = !full && payload_accept;
    assign wr_en = s_payload_tvalid && s_payload_tready;

    assign m_payload_tvalid = !empty;
    assign rd_en = m_payload_tvalid && m_payload_tready;

    // head of queue read straight from the array
    assign m_payload_tdata = data_mem[rd_ptr[ADDR_W-1:0]];
    assign m_payload_tlast = last_mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_ptr[ADDR_W-1:0]] <= s_payload_tdata;
            last_mem[wr_ptr[ADDR_W-1:0]] <= s_payload_tlast;
        end
    end

    // a full buffer with nothing drained keeps its write pointer
    assert property (@(posedge clk) disable iff (rst)
        (full && !rd_en) |=> $stable(wr_ptr));

endmodule

// File: rtl/header_queue.sv
// queue of finished headers with a registered output stage
// and the derived ip length and protocol fields
`timescale 1ns/1ps

module header_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    result_valid,
    input  udp_csum_pkg::ip_addr_t  result_source_ip,
    input  udp_csum_pkg::ip_addr_t  result_dest_ip,
    input  udp_csum_pkg::udp_port_t result_source_port,
    input  udp_csum_pkg::udp_port_t result_dest_port,
    input  udp_csum_pkg::udp_len_t  result_length,
    input  udp_csum_pkg::csum_t     result_checksum,
    output logic                    queue_ready,
    output logic                    m_hdr_valid,
    input  logic                    m_hdr_ready,
    output udp_csum_pkg::ip_addr_t  m_ip_source_ip,
    output udp_csum_pkg::ip_addr_t  m_ip_dest_ip,
    output udp_csum_pkg::udp_port_t m_udp_source_port,
    output udp_csum_pkg::udp_port_t m_udp_dest_port,
    output udp_csum_pkg::udp_len_t  m_udp_length,
    output udp_csum_pkg::csum_t     m_udp_checksum,
    output udp_csum_pkg::udp_len_t  m_ip_length,
    output logic [7:0]              m_ip_protocol
);
    import udp_csum_pkg::*;

    localparam int AW = HEADER_QUEUE_ADDR_W;

    ip_addr_t  src_ip_mem   [HEADER_QUEUE_DEPTH];
    ip_addr_t  dst_ip_mem   [HEADER_QUEUE_DEPTH];
    udp_port_t src_port_mem [HEADER_QUEUE_DEPTH];
    udp_port_t dst_port_mem [HEADER_QUEUE_DEPTH];
    udp_len_t  length_mem   [HEADER_QUEUE_DEPTH];
    csum_t     csum_mem     [HEADER_QUEUE_DEPTH];

    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;
    logic        out_free;
    logic        mem_read;
    logic        mem_write;
    logic        bypass;

    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);
    assign queue_ready = !full;

    // output register empty or handing over this cycle
    assign out_free = m_hdr_ready || !m_hdr_valid;
    assign mem_read = out_free && !empty;

    // empty queue lets a fresh result skip the memory
    assign bypass = out_free && empty && result_valid;
    assign mem_write = result_valid && !bypass;

    assign m_ip_length = m_udp_length + IP_HDR_BYTES;
    assign m_ip_protocol = UDP_PROTOCOL;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            m_hdr_valid <= 1'b0;
        end else begin
            if (mem_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (out_free) begin
                m_hdr_valid <= mem_read || bypass;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_write) begin
            src_ip_mem[wr_ptr[AW-1:0]] <= result_source_ip;
            dst_ip_mem[wr_ptr[AW-1:0]] <= result_dest_ip;
            src_port_mem[wr_ptr[AW-1:0]] <= result_source_port;
            dst_port_mem[wr_ptr[AW-1:0]] <= result_dest_port;
            length_mem[wr_ptr[AW-1:0]] <= result_length;
            csum_mem[wr_ptr[AW-1:0]] <= result_checksum;
        end

        if (mem_read) begin
            m_ip_source_ip <= src_ip_mem[rd_ptr[AW-1:0]];
            m_ip_dest_ip <= dst_ip_mem[rd_ptr[AW-1:0]];
            m_udp_source_port <= src_port_mem[rd_ptr[AW-1:0]];
            m_udp_dest_port <= dst_port_mem[rd_ptr[AW-1:0]];
            m_udp_length <= length_mem[rd_ptr[AW-1:0]];
            m_udp_checksum <= csum_mem[rd_ptr[AW-1:0]];
        end else if (bypass) begin
            m_ip_source_ip <= result_source_ip;
            m_ip_dest_ip <= result_dest_ip;
            m_udp_source_port <= result_source_port;
            m_udp_dest_port <= result_dest_port;
            m_udp_length <= result_length;
            m_udp_checksum <= result_checksum;
        end
    end

    // engine only starts a frame when a slot was free
    assert property (@(posedge clk) disable iff (rst) result_valid |-> !full);

endmodule

// File: rtl/udp_checksum_gen.sv
// udp checksum generator top
// engine and payload fifo side by side, header queue on the result
`timescale 1ns/1ps

module udp_checksum_gen (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        s_hdr_valid,
    output logic                        s_hdr_ready,
    input  udp_csum_pkg::ip_addr_t      s_ip_source_ip,
    input  udp_csum_pkg::ip_addr_t      s_ip_dest_ip,
    input  udp_csum_pkg::udp_port_t     s_udp_source_port,
    input  udp_csum_pkg::udp_port_t     s_udp_dest_port,
    input  udp_csum_pkg::payload_byte_t s_payload_tdata,
    input  logic                        s_payload_tvalid,
    output logic                        s_payload_tready,
    input  logic                        s_payload_tlast,
    output logic                        m_hdr_valid,
    input  logic                        m_hdr_ready,
    output udp_csum_pkg::ip_addr_t      m_ip_source_ip,
    output udp_csum_pkg::ip_addr_t      m_ip_dest_ip,
    output udp_csum_pkg::udp_port_t     m_udp_source_port,
    output udp_csum_pkg::udp_port_t     m_udp_dest_port,
    output udp_csum_pkg::udp_len_t      m_udp_length,
    output udp_csum_pkg::csum_t         m_udp_checksum,
    output udp_csum_pkg::udp_len_t      m_ip_length,
    output logic [7:0]                  m_ip_protocol,
    output udp_csum_pkg::payload_byte_t m_payload_tdata,
    output logic                        m_payload_tvalid,
    input  logic                        m_payload_tready,
    output logic                        m_payload_tlast,
    output logic                        busy
);
    import udp_csum_pkg::*;

    // engine to fifo and queue
    logic      payload_accept;
    logic      queue_ready;
    logic      result_valid;
    ip_addr_t  result_source_ip;
    ip_addr_t  result_dest_ip;
    udp_port_t result_source_port;
    udp_port_t result_dest_port;
    udp_len_t  result_length;
    csum_t     result_checksum;

    // port names match the top level signals
    udp_csum_engine udp_csum_engine_i (
        .*
    );

    payload_fifo #(
        .DEPTH(PAYLOAD_FIFO_DEPTH)
    ) payload_fifo_i (
        .*
    );

    header_queue header_queue_i (
        .*
    );

endmodule

// File: verif/udp_checksum_gen_tb.sv
// testbench for the udp checksum generator
// random frames, reference checksum, output back-pressure and header queue fill
`timescale 1ns/1ps

module udp_checksum_gen_tb;
    import udp_csum_pkg::*;

    localparam int NUM_FRAMES   = 40;
    localparam int MAX_LEN      = 64;
    localparam int HOLD_FIRST   = 12;
    // queue entries plus the output register
    localparam int HDR_CAPACITY = HEADER_QUEUE_DEPTH + 1;
    localparam int CYCLE_LIMIT  = NUM_FRAMES * (4 * MAX_LEN + 40) + 1000;

    logic          clk;
    logic          rst;
    logic          s_hdr_valid;
    logic          s_hdr_ready;
    ip_addr_t      s_ip_source_ip;
    ip_addr_t      s_ip_dest_ip;
    udp_port_t     s_udp_source_port;
    udp_port_t     s_udp_dest_port;
    payload_byte_t s_payload_tdata;
    logic          s_payload_tvalid;
    logic          s_payload_tready;
    logic          s_payload_tlast;
    logic          m_hdr_valid;
    logic          m_hdr_ready;
    ip_addr_t      m_ip_source_ip;
    ip_addr_t      m_ip_dest_ip;
    udp_port_t     m_udp_source_port;
    udp_port_t     m_udp_dest_port;
    udp_len_t      m_udp_length;
    csum_t         m_udp_checksum;
    udp_len_t      m_ip_length;
    logic [7:0]    m_ip_protocol;
    payload_byte_t m_payload_tdata;
    logic          m_payload_tvalid;
    logic          m_payload_tready;
    logic          m_payload_tlast;
    logic          busy;

    // expected results in frame order
    ip_addr_t      exp_src[$];
    ip_addr_t      exp_dst[$];
    udp_port_t     exp_sport[$];
    udp_port_t     exp_dport[$];
    udp_len_t      exp_len[$];
    csum_t         exp_csum[$];
    payload_byte_t exp_byte[$];
    logic          exp_last[$];

    payload_byte_t frame_data [MAX_LEN];
    integer        stim_seed = 32'hc9b47997;
    integer        bp_seed = 32'hc9b47997;
    int            hdr_in_count = 0;
    int            hdr_out_count = 0;
    int            byte_out_count = 0;
    int            full_cycles = 0;
    int            cycle_count = 0;
    logic          hold_req = 1'b0;
    logic          hold_done = 1'b0;

    udp_checksum_gen udp_checksum_gen_i (
        .*
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic report_error(string msg);
        stop_run($sformatf("** Error at %0t: %s", $time, msg));
    endtask

    // sum of pseudo header, udp header and padded payload folded twice and inverted
    function automatic csum_t ref_checksum(ip_addr_t src, ip_addr_t dst, udp_port_t sport,
            udp_port_t dport, int len);
        logic [31:0] sum;
        logic [16:0] fold;
        logic [15:0] word;
        csum_t       folded;
        udp_len_t    ulen;
        int          i;
        ulen = udp_len_t'(len + 8);
        sum = 32'(src[31:16]) + src[15:0] + dst[31:16] + dst[15:0] + 32'd17;
        sum = sum + ulen + ulen + sport + dport;
        for (i = 0; i < len; i = i + 2) begin
            word = {frame_data[i], (i + 1 < len) ? frame_data[i + 1] : 8'h00};
            sum = sum + word;
        end
        fold = sum[15:0] + sum[31:16];
        folded = fold[15:0] + fold[16];
        return ~folded;
    endfunction

    task automatic check_flag(logic got, logic exp, string name);
        if (got !== exp) begin
            report_error($sformatf("%s is %b, expected %b", name, got, exp));
        end
    endtask

    task automatic check_hdr(ip_addr_t src, ip_addr_t dst, udp_port_t sport,
            udp_port_t dport, udp_len_t len, csum_t csum);
        // ip total length adds the 20 byte ip header and protocol 17 is udp
        if (m_ip_source_ip !== src || m_ip_dest_ip !== dst || m_udp_source_port !== sport
                || m_udp_dest_port !== dport || m_udp_length !== len
                || m_udp_checksum !== csum || m_ip_length !== len + 16'd20
                || m_ip_protocol !== 8'd17) begin
            report_error({$sformatf("header %0d got %h %h %h %h len %h csum %h ip_len %h ",
                hdr_out_count, m_ip_source_ip, m_ip_dest_ip, m_udp_source_port,
                m_udp_dest_port, m_udp_length, m_udp_checksum, m_ip_length),
                $sformatf("proto %0d, expected %h %h %h %h len %h csum %h",
                m_ip_protocol, src, dst, sport, dport, len, csum)});
        end
        hdr_out_count++;
    endtask

    task automatic check_byte(payload_byte_t data, logic last);
        if (m_payload_tdata !== data || m_payload_tlast !== last) begin
            report_error($sformatf("payload byte %0d got %h last %b, expected %h last %b",
                byte_out_count, m_payload_tdata, m_payload_tlast, data, last));
        end
        byte_out_count++;
    endtask

    task automatic send_header(ip_addr_t src, ip_addr_t dst, udp_port_t sport,
            udp_port_t dport);
        s_hdr_valid = 1'b1;
        s_ip_source_ip = src;
        s_ip_dest_ip = dst;
        s_udp_source_port = sport;
        s_udp_dest_port = dport;
        while (!s_hdr_ready) @(negedge clk);
        @(negedge clk);
        s_hdr_valid = 1'b0;
        hdr_in_count <= hdr_in_count + 1;
    endtask

    // engine must stay busy from header transfer to the tlast byte
    task automatic send_byte(payload_byte_t data, logic last, int gap);
        repeat (gap) begin
            check_flag(busy, 1'b1, "busy during frame");
            @(negedge clk);
        end
        s_payload_tvalid = 1'b1;
        s_payload_tdata = data;
        s_payload_tlast = last;
        check_flag(busy, 1'b1, "busy during frame");
        while (!s_payload_tready) begin
            @(negedge clk);
            check_flag(busy, 1'b1, "busy during frame");
        end
        @(negedge clk);
        s_payload_tvalid = 1'b0;
        s_payload_tlast = 1'b0;
    endtask

    initial begin : output_side
        m_hdr_ready = 1'b0;
        m_payload_tready = 1'b0;
        @(negedge rst);
        forever begin
            @(negedge clk);
            if (hold_req && !hold_done) begin
                m_hdr_ready = 1'b0;
            end else begin
                m_hdr_ready = ($unsigned($random(bp_seed)) % 4) != 0;
            end
            m_payload_tready = ($unsigned($random(bp_seed)) % 3) != 0;
            if (m_hdr_valid && m_hdr_ready) begin
                if (exp_len.size() == 0) begin
                    report_error("header output with no frame pending");
                end else begin
                    check_hdr(exp_src.pop_front(), exp_dst.pop_front(),
                        exp_sport.pop_front(), exp_dport.pop_front(),
                        exp_len.pop_front(), exp_csum.pop_front());
                end
            end
            if (m_payload_tvalid && m_payload_tready) begin
                if (exp_byte.size() == 0) begin
                    report_error("payload byte output with no frame pending");
                end else begin
                    check_byte(exp_byte.pop_front(), exp_last.pop_front());
                end
            end
            // idle engine with a full queue must hold s_hdr_ready low
            if (hold_req && !hold_done) begin
                if (hdr_in_count - hdr_out_count > HDR_CAPACITY) begin
                    report_error("header accepted while the header queue was full");
                end
                if (!s_hdr_ready && !busy
                        && hdr_in_count - hdr_out_count == HDR_CAPACITY) begin
                    full_cycles++;
                end
                if (full_cycles == 16) begin
                    hold_done <= 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        stop_run($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
    end

    initial begin : stimulus
        ip_addr_t  src;
        ip_addr_t  dst;
        udp_port_t sport;
        udp_port_t dport;
        int        len;
        int        f;
        int        i;
        rst = 1'b1;
        s_hdr_valid = 1'b0;
        s_ip_source_ip = '0;
        s_ip_dest_ip = '0;
        s_udp_source_port = '0;
        s_udp_dest_port = '0;
        s_payload_tdata = '0;
        s_payload_tvalid = 1'b0;
        s_payload_tlast = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_flag(s_hdr_ready, 1'b0, "s_hdr_ready in reset");
        check_flag(s_payload_tready, 1'b0, "s_payload_tready in reset");
        check_flag(m_hdr_valid, 1'b0, "m_hdr_valid in reset");
        check_flag(m_payload_tvalid, 1'b0, "m_payload_tvalid in reset");
        check_flag(busy, 1'b0, "busy in reset");
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_flag(m_hdr_valid, 1'b0, "m_hdr_valid before first frame");
            check_flag(m_payload_tvalid, 1'b0, "m_payload_tvalid before first frame");
            check_flag(busy, 1'b0, "busy before first frame");
        end

        for (f = 0; f < NUM_FRAMES; f++) begin
            if (f == HOLD_FIRST) begin
                hold_req <= 1'b1;
            end
            // shortest and longest frame first and random lengths after
            if (f == 0) begin
                len = 1;
            end else if (f == 1) begin
                len = MAX_LEN;
            end else begin
                len = 1 + $unsigned($random(stim_seed)) % MAX_LEN;
            end
            src = $random(stim_seed);
            dst = $random(stim_seed);
            sport = udp_port_t'($random(stim_seed));
            dport = udp_port_t'($random(stim_seed));
            for (i = 0; i < len; i++) begin
                frame_data[i] = payload_byte_t'($random(stim_seed));
                exp_byte.push_back(frame_data[i]);
                exp_last.push_back(i == len - 1);
            end
            exp_src.push_back(src);
            exp_dst.push_back(dst);
            exp_sport.push_back(sport);
            exp_dport.push_back(dport);
            exp_len.push_back(udp_len_t'(len + 8));
            exp_csum.push_back(ref_checksum(src, dst, sport, dport, len));

            // s_hdr_ready lags the queue write by a cycle
            if (f >= HOLD_FIRST && !hold_done) begin
                while (busy) @(negedge clk);
                repeat (4) @(negedge clk);
            end
            send_header(src, dst, sport, dport);
            for (i = 0; i < len; i++) begin
                send_byte(frame_data[i], i == len - 1,
                    ($unsigned($random(stim_seed)) % 5 == 0) ? 1 : 0);
            end
        end

        while (exp_len.size() != 0 || exp_byte.size() != 0) @(negedge clk);
        // nothing may follow the last expected header and byte
        repeat (2) @(negedge clk);
        check_flag(m_hdr_valid, 1'b0, "m_hdr_valid after all frames");
        check_flag(m_payload_tvalid, 1'b0, "m_payload_tvalid after all frames");
        check_flag(busy, 1'b0, "busy after all frames");
        if (hold_done) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_run("header queue never filled while m_hdr_ready was held low");
        end
    end

endmodule

// File: udp_checksum_gen.f
rtl/udp_csum_pkg.sv
rtl/udp_csum_engine.sv
rtl/payload_fifo.sv
rtl/header_queue.sv
rtl/udp_checksum_gen.sv
verif/udp_checksum_gen_tb.sv

// File: Bender.yml
package:
  name: udp_checksum_gen

sources:
  - rtl/udp_csum_pkg.sv
  - rtl/udp_csum_engine.sv
  - rtl/payload_fifo.sv
  - rtl/header_queue.sv
  - rtl/udp_checksum_gen.sv
  - target: test
    files:
      - verif/udp_checksum_gen_tb.sv
